//--- Makefile
TOP = tb_cpu_read_port

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f cpu_read_port.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/axi_read_memory.sv
`include "cpu_read_port_defines.svh"

// axi4-lite read slave, beat is a function of the address
module axi_read_memory (
	input logic clock,
	input logic reset,
	input logic ar_valid,
	output logic ar_ready,
	input logic [`ADDR_WIDTH-1:0] ar_addr,
	output logic r_valid,
	input logic r_ready,
	output logic [`DATA_WIDTH-1:0] r_data,
	output cpu_read_port_pkg::resp_t r_resp
);

	integer seed;
	logic busy; // address taken, response pending
	logic [1:0] delay;
	logic [`ADDR_WIDTH-1:0] aligned;

	initial seed = 32'hb241;

	assign aligned = {ar_addr[`ADDR_WIDTH-1:3], 3'b000};

	always @(posedge clock) begin
		if (reset) begin
			ar_ready <= 1'b0;
			r_valid <= 1'b0;
			busy <= 1'b0;
			delay <= 2'd0;
		end else if (r_valid) begin
			if (r_ready) begin
				r_valid <= 1'b0;
				busy <= 1'b0;
				delay <= 2'($random(seed)); // gap before next ar_ready
			end
		end else if (busy) begin
			if (delay == 2'd0)
				r_valid <= 1'b1;
			else
				delay <= delay - 2'd1;
		end else if (ar_ready) begin
			if (ar_valid) begin
				ar_ready <= 1'b0;
				busy <= 1'b1;
				delay <= 2'($random(seed));
				r_data <= {~aligned, aligned};
				r_resp <= ar_addr[`ADDR_WIDTH-1] ? 2'd2 : 2'd0; // slverr in upper half
			end
		end else if (delay == 2'd0) begin
			ar_ready <= 1'b1;
		end else begin
			delay <= delay - 2'd1;
		end
	end

endmodule

//--- bench/tb_cpu_read_port.sv
`include "cpu_read_port_defines.svh"

module tb_cpu_read_port;

	localparam int TIMEOUT = 100;
	localparam int NUM_ENTRIES = 8;

	typedef struct packed {
		logic is_data;
		logic [`ADDR_WIDTH-1:0] addr;
		logic [31:0] hold; // cycles with upstream r_ready low
		logic [`DATA_WIDTH-1:0] exp_data;
		cpu_read_port_pkg::resp_t exp_resp;
	} entry_t;

	logic clock = 1'b0;
	logic reset;
	logic fetch_ar_valid;
	logic fetch_ar_ready;
	logic [`ADDR_WIDTH-1:0] fetch_ar_addr;
	logic fetch_r_valid;
	logic fetch_r_ready;
	logic [`INSN_WIDTH-1:0] fetch_r_data;
	cpu_read_port_pkg::resp_t fetch_r_resp;
	logic data_ar_valid;
	logic data_ar_ready;
	logic [`ADDR_WIDTH-1:0] data_ar_addr;
	logic data_r_valid;
	logic data_r_ready;
	logic [`DATA_WIDTH-1:0] data_r_data;
	cpu_read_port_pkg::resp_t data_r_resp;
	logic m_ar_valid;
	logic m_ar_ready;
	logic [`ADDR_WIDTH-1:0] m_ar_addr;
	logic m_r_valid;
	logic m_r_ready;
	logic [`DATA_WIDTH-1:0] m_r_data;
	cpu_read_port_pkg::resp_t m_r_resp;

	entry_t stim [NUM_ENTRIES];

	always #5 clock = ~clock;

	cpu_read_port cpu_read_port_inst (
		.clock (clock),
		.reset (reset),
		.fetch_ar_valid (fetch_ar_valid),
		.fetch_ar_ready (fetch_ar_ready),
		.fetch_ar_addr (fetch_ar_addr),
		.fetch_r_valid (fetch_r_valid),
		.fetch_r_ready (fetch_r_ready),
		.fetch_r_data (fetch_r_data),
		.fetch_r_resp (fetch_r_resp),
		.data_ar_valid (data_ar_valid),
		.data_ar_ready (data_ar_ready),
		.data_ar_addr (data_ar_addr),
		.data_r_valid (data_r_valid),
		.data_r_ready (data_r_ready),
		.data_r_data (data_r_data),
		.data_r_resp (data_r_resp),
		.m_ar_valid (m_ar_valid),
		.m_ar_ready (m_ar_ready),
		.m_ar_addr (m_ar_addr),
		.m_r_valid (m_r_valid),
		.m_r_ready (m_r_ready),
		.m_r_data (m_r_data),
		.m_r_resp (m_r_resp)
	);

	axi_read_memory memory (
		.clock (clock),
		.reset (reset),
		.ar_valid (m_ar_valid),
		.ar_ready (m_ar_ready),
		.ar_addr (m_ar_addr),
		.r_valid (m_r_valid),
		.r_ready (m_r_ready),
		.r_data (m_r_data),
		.r_resp (m_r_resp)
	);

	function automatic string port_name(input logic is_data);
		return is_data ? "data" : "fetch";
	endfunction

	function automatic logic [63:0] ar_ready_of(input logic is_data);
		return is_data ? 64'(data_ar_ready) : 64'(fetch_ar_ready);
	endfunction

	function automatic logic [63:0] r_valid_of(input logic is_data);
		return is_data ? 64'(data_r_valid) : 64'(fetch_r_valid);
	endfunction

	function automatic logic [63:0] r_data_of(input logic is_data);
		return is_data ? data_r_data : 64'(fetch_r_data); // fetch zero extended
	endfunction

	function automatic logic [63:0] r_resp_of(input logic is_data);
		return is_data ? 64'(data_r_resp) : 64'(fetch_r_resp);
	endfunction

	task automatic stop_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		if (got !== expected) begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, got, expected);
			stop_run();
		end
	endtask

	task automatic drive_ar(input logic is_data, input logic valid,
			input logic [`ADDR_WIDTH-1:0] addr);
		if (is_data) begin
			data_ar_valid <= valid;
			data_ar_addr <= addr;
		end else begin
			fetch_ar_valid <= valid;
			fetch_ar_addr <= addr;
		end
	endtask

	task automatic drive_r_ready(input logic is_data, input logic ready);
		if (is_data)
			data_r_ready <= ready;
		else
			fetch_r_ready <= ready;
	endtask

	task automatic wait_for_ar_ready(input logic is_data);
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (ar_ready_of(is_data) != 64'd1) begin
			if (cycles == TIMEOUT) begin
				$display("%s_ar_ready never went high", port_name(is_data));
				stop_run();
			end
			cycles++;
			@(negedge clock);
		end
	endtask

	task automatic wait_for_r_valid(input logic is_data);
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (r_valid_of(is_data) != 64'd1) begin
			// the slot takes the beat even while upstream stalls
			if (m_r_valid === 1'b1)
				check_value("m_r_ready", 64'(m_r_ready), 64'd1);
			if (cycles == TIMEOUT) begin
				$display("no response on %s port, r_valid stayed low", port_name(is_data));
				stop_run();
			end
			cycles++;
			@(negedge clock);
		end
	endtask

	task automatic wait_for_m_ar_valid();
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (m_ar_valid !== 1'b1) begin
			if (cycles == TIMEOUT) begin
				$display("master never issued a read address");
				stop_run();
			end
			cycles++;
			@(negedge clock);
		end
	endtask

	// returned beat while upstream has not taken it yet
	task automatic check_response(input entry_t e);
		string name;
		name = port_name(e.is_data);
		check_value($sformatf("%s_r_valid", name), r_valid_of(e.is_data), 64'd1);
		check_value($sformatf("%s_r_data", name), r_data_of(e.is_data), e.exp_data);
		check_value($sformatf("%s_r_resp", name), r_resp_of(e.is_data), 64'(e.exp_resp));
		check_value($sformatf("%s_ar_ready", name), ar_ready_of(e.is_data), 64'd0);
	endtask

	task automatic run_entry(input entry_t e);
		@(posedge clock);
		drive_ar(e.is_data, 1'b1, e.addr);
		drive_r_ready(e.is_data, e.hold == 0);
		wait_for_ar_ready(e.is_data);
		@(posedge clock);
		drive_ar(e.is_data, 1'b0, e.addr);
		wait_for_r_valid(e.is_data);
		repeat (e.hold) begin
			check_response(e);
			@(negedge clock);
		end
		check_response(e);
		if (e.hold != 0) begin
			@(posedge clock);
			drive_r_ready(e.is_data, 1'b1);
		end
		@(posedge clock); // r handshake edge
		drive_r_ready(e.is_data, 1'b0);
		@(negedge clock);
		check_value($sformatf("%s_r_valid", port_name(e.is_data)), r_valid_of(e.is_data), 64'd0);
		check_value($sformatf("%s_ar_ready", port_name(e.is_data)), ar_ready_of(e.is_data),
			64'd1);
	endtask

	// fetch and data accepted together and data must reach the bus first
	task automatic run_pair();
		@(posedge clock);
		drive_ar(1'b1, 1'b1, 32'h0000_4000);
		drive_ar(1'b0, 1'b1, 32'h0000_5004);
		drive_r_ready(1'b1, 1'b1);
		drive_r_ready(1'b0, 1'b1);
		wait_for_ar_ready(1'b1);
		@(posedge clock);
		drive_ar(1'b1, 1'b0, 32'h0000_4000);
		drive_ar(1'b0, 1'b0, 32'h0000_5004);
		@(negedge clock);
		// both slots took their request on the same edge
		check_value("data_ar_ready", 64'(data_ar_ready), 64'd0);
		check_value("fetch_ar_ready", 64'(fetch_ar_ready), 64'd0);
		wait_for_m_ar_valid();
		check_value("m_ar_addr", 64'(m_ar_addr), 64'h0000_4000);
		wait_for_r_valid(1'b1);
		check_value("data_r_data", data_r_data, 64'hffff_bfff_0000_4000);
		check_value("data_r_resp", 64'(data_r_resp), 64'd0);
		wait_for_r_valid(1'b0);
		check_value("fetch_r_data", 64'(fetch_r_data), 64'h0000_0000_ffff_afff);
		check_value("fetch_r_resp", 64'(fetch_r_resp), 64'd0);
		@(posedge clock);
		drive_r_ready(1'b1, 1'b0);
		drive_r_ready(1'b0, 1'b0);
	endtask

	initial begin
		int i;
		reset <= 1'b1;
		fetch_ar_valid <= 1'b0;
		fetch_ar_addr <= '0;
		fetch_r_ready <= 1'b0;
		data_ar_valid <= 1'b0;
		data_ar_addr <= '0;
		data_r_ready <= 1'b0;
		// port, address, hold cycles, expected beat, expected resp
		stim[0] = '{1'b0, 32'h0000_1000, 32'd0, 64'h0000_0000_0000_1000, 2'd0};
		stim[1] = '{1'b0, 32'h0000_1004, 32'd0, 64'h0000_0000_ffff_efff, 2'd0};
		stim[2] = '{1'b1, 32'h0000_2008, 32'd0, 64'hffff_dff7_0000_2008, 2'd0};
		stim[3] = '{1'b1, 32'h0000_0105, 32'd2, 64'hffff_feff_0000_0100, 2'd0};
		stim[4] = '{1'b1, 32'h8000_0010, 32'd0, 64'h7fff_ffef_8000_0010, 2'd2};
		stim[5] = '{1'b0, 32'h8000_0024, 32'd3, 64'h0000_0000_7fff_ffdf, 2'd2};
		stim[6] = '{1'b0, 32'h0000_3002, 32'd1, 64'h0000_0000_0000_3000, 2'd0};
		stim[7] = '{1'b0, 32'h0000_300c, 32'd0, 64'h0000_0000_ffff_cff7, 2'd0};
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_value("fetch_r_valid", 64'(fetch_r_valid), 64'd0);
		check_value("data_r_valid", 64'(data_r_valid), 64'd0);
		check_value("m_ar_valid", 64'(m_ar_valid), 64'd0);
		check_value("fetch_ar_ready", 64'(fetch_ar_ready), 64'd1);
		check_value("data_ar_ready", 64'(data_ar_ready), 64'd1);
		for (i = 0; i < NUM_ENTRIES; i++)
			run_entry(stim[i]);
		run_pair();
		repeat (2) @(posedge clock);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- cpu_read_port.f
+incdir+design
design/cpu_read_port_pkg.sv
design/rd_port_if.sv
design/read_req_slot.sv
design/read_arbiter.sv
design/cpu_read_port.sv
bench/axi_read_memory.sv
bench/tb_cpu_read_port.sv

//--- design/cpu_read_port.sv
module cpu_read_port (
	input logic clock,
	input logic reset,

	input logic fetch_ar_valid,
	output logic fetch_ar_ready,
	input cpu_read_port_pkg::addr_t fetch_ar_addr,
	output logic fetch_r_valid,
	input logic fetch_r_ready,
	output cpu_read_port_pkg::insn_t fetch_r_data,
	output cpu_read_port_pkg::resp_t fetch_r_resp,

	input logic data_ar_valid,
	output logic data_ar_ready,
	input cpu_read_port_pkg::addr_t data_ar_addr,
	output logic data_r_valid,
	input logic data_r_ready,
	output cpu_read_port_pkg::data_t data_r_data,
	output cpu_read_port_pkg::resp_t data_r_resp,

	output logic m_ar_valid,
	input logic m_ar_ready,
	output cpu_read_port_pkg::addr_t m_ar_addr,
	input logic m_r_valid,
	output logic m_r_ready,
	input cpu_read_port_pkg::data_t m_r_data,
	input cpu_read_port_pkg::resp_t m_r_resp
);

	cpu_read_port_pkg::data_t fetch_r_wide; // upper half is zero

	rd_port_if fetch_port ();
	rd_port_if data_port ();

	assign fetch_r_data = cpu_read_port_pkg::insn_t'(fetch_r_wide);

	read_req_slot #(.NARROW(1)) fetch_slot (
		.clock (clock),
		.reset (reset),
		.up_ar_valid (fetch_ar_valid),
		.up_ar_addr (fetch_ar_addr),
		.up_r_ready (fetch_r_ready),
		.up_ar_ready (fetch_ar_ready),
		.up_r_valid (fetch_r_valid),
		.up_r_data (fetch_r_wide),
		.up_r_resp (fetch_r_resp),
		.port (fetch_port.requester)
	);

	read_req_slot #(.NARROW(0)) data_slot (
		.clock (clock),
		.reset (reset),
		.up_ar_valid (data_ar_valid),
		.up_ar_addr (data_ar_addr),
		.up_r_ready (data_r_ready),
		.up_ar_ready (data_ar_ready),
		.up_r_valid (data_r_valid),
		.up_r_data (data_r_data),
		.up_r_resp (data_r_resp),
		.port (data_port.requester)
	);

	read_arbiter arbiter (
		.clock (clock),
		.reset (reset),
		.m_ar_ready (m_ar_ready),
		.m_r_valid (m_r_valid),
		.m_r_data (m_r_data),
		.m_r_resp (m_r_resp),
		.m_ar_valid (m_ar_valid),
		.m_ar_addr (m_ar_addr),
		.m_r_ready (m_r_ready),
		.fetch (fetch_port.completer),
		.data (data_port.completer)
	);

endmodule

//--- design/cpu_read_port_defines.svh
`ifndef CPU_READ_PORT_DEFINES_SVH
`define CPU_READ_PORT_DEFINES_SVH

// bus and payload widths

`define ADDR_WIDTH 32
`define DATA_WIDTH 64
`define INSN_WIDTH 32
`define RESP_WIDTH 2 // axi resp code

`endif

//--- design/cpu_read_port_pkg.sv
`include "cpu_read_port_defines.svh"

package cpu_read_port_pkg;

	typedef logic [`ADDR_WIDTH-1:0] addr_t;
	typedef logic [`DATA_WIDTH-1:0] data_t;
	typedef logic [`INSN_WIDTH-1:0] insn_t;
	typedef logic [`RESP_WIDTH-1:0] resp_t;

	// one bus beat, seen whole by data reads, as two halves by fetch
	typedef union packed {
		data_t dword;
		insn_t [1:0] half; // half[0] is the low word
	} read_beat_t;

	typedef enum logic [1:0] {
		owner_none,
		owner_fetch,
		owner_data
	} owner_t;

endpackage

//--- design/rd_port_if.sv
`include "cpu_read_port_defines.svh"

// one requester's read channel between its slot and the arbiter
interface rd_port_if;

	logic ar_valid;
	logic ar_ready;
	logic [`ADDR_WIDTH-1:0] ar_addr;
	logic r_valid;
	logic r_ready;
	logic [`DATA_WIDTH-1:0] r_data;
	logic [`RESP_WIDTH-1:0] r_resp;

	modport requester (
		output ar_valid,
		output ar_addr,
		output r_ready,
		input ar_ready,
		input r_valid,
		input r_data,
		input r_resp
	);

	modport completer (
		input ar_valid,
		input ar_addr,
		input r_ready,
		output ar_ready,
		output r_valid,
		output r_data,
		output r_resp
	);

endinterface

//--- design/read_arbiter.sv
module read_arbiter (
	input logic clock,
	input logic reset,
	input logic m_ar_ready,
	input logic m_r_valid,
	input cpu_read_port_pkg::data_t m_r_data,
	input cpu_read_port_pkg::resp_t m_r_resp,
	output logic m_ar_valid,
	output cpu_read_port_pkg::addr_t m_ar_addr,
	output logic m_r_ready,
	rd_port_if.completer fetch,
	rd_port_if.completer data
);

	cpu_read_port_pkg::owner_t owner;
	logic idle;
	logic r_phase;
	logic own_fetch;
	logic own_data;
	logic ar_fire;
	logic r_fire;

	assign idle = (owner == cpu_read_port_pkg::owner_none);
	assign own_fetch = (owner == cpu_read_port_pkg::owner_fetch);
	assign own_data = (owner == cpu_read_port_pkg::owner_data);
	assign r_phase = !idle && !m_ar_valid; // ar done and waiting on r

	assign ar_fire = m_ar_valid && m_ar_ready;
	assign r_fire = m_r_valid && m_r_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			owner <= cpu_read_port_pkg::owner_none;
			m_ar_valid <= 1'b0;
		end else if (idle) begin
			// data wins over fetch
			if (data.ar_valid) begin
				owner <= cpu_read_port_pkg::owner_data;
				m_ar_valid <= 1'b1;
			end else if (fetch.ar_valid) begin
				owner <= cpu_read_port_pkg::owner_fetch;
				m_ar_valid <= 1'b1;
			end
		end else begin
			if (ar_fire)
				m_ar_valid <= 1'b0;
			if (r_fire)
				owner <= cpu_read_port_pkg::owner_none;
		end
	end

	assign m_ar_addr = own_data ? data.ar_addr : fetch.ar_addr;

	// ar ready only reaches the granted slot
	assign data.ar_ready = m_ar_valid && own_data && m_ar_ready;
	assign fetch.ar_ready = m_ar_valid && own_fetch && m_ar_ready;

	always_comb begin
		m_r_ready = 1'b0;
		if (r_phase)
			m_r_ready = own_data ? data.r_ready : fetch.r_ready;
	end

	assign data.r_valid = r_phase && own_data && m_r_valid;
	assign fetch.r_valid = r_phase && own_fetch && m_r_valid;

	// payload fans out and valid does the routing
	assign data.r_data = m_r_data;
	assign data.r_resp = m_r_resp;
	assign fetch.r_data = m_r_data;
	assign fetch.r_resp = m_r_resp;

	// a beat with no owner would be lost
	r_owned_a: assert property (@(posedge clock) disable iff (reset)
		m_r_valid |-> !idle);

	// address comes from the slot so this checks the slot holds it too
	m_ar_hold_a: assert property (@(posedge clock) disable iff (reset)
		m_ar_valid && !m_ar_ready |=> m_ar_valid && $stable(m_ar_addr));

endmodule

//--- design/read_req_slot.sv
`include "cpu_read_port_defines.svh"

module read_req_slot #(
	parameter int NARROW = 0
) (
	input logic clock,
	input logic reset,
	input logic up_ar_valid,
	input cpu_read_port_pkg::addr_t up_ar_addr,
	input logic up_r_ready,
	output logic up_ar_ready,
	output logic up_r_valid,
	output cpu_read_port_pkg::data_t up_r_data,
	output cpu_read_port_pkg::resp_t up_r_resp,
	rd_port_if.requester port
);

	typedef enum logic [1:0] {
		st_empty,
		st_request,
		st_return
	} slot_state_t;

	slot_state_t state;
	logic issued; // ar already taken by the arbiter
	cpu_read_port_pkg::addr_t addr_q;
	cpu_read_port_pkg::read_beat_t beat;
	cpu_read_port_pkg::resp_t resp_q;

	assign up_ar_ready = (state == st_empty);
	assign up_r_valid = (state == st_return);
	assign up_r_resp = resp_q;

	assign port.ar_valid = (state == st_request) && !issued;
	assign port.ar_addr = addr_q;
	assign port.r_ready = (state == st_request) && issued;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_empty;
			issued <= 1'b0;
		end else begin
			case (state)
				st_empty: begin
					if (up_ar_valid) begin
						state <= st_request;
						issued <= 1'b0;
					end
				end
				st_request: begin
					if (port.ar_valid && port.ar_ready)
						issued <= 1'b1;
					if (port.r_valid && port.r_ready)
						state <= st_return;
				end
				st_return: begin
					if (up_r_ready)
						state <= st_empty; // upstream took the beat
				end
				default: state <= st_empty;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (up_ar_valid && up_ar_ready)
			addr_q <= up_ar_addr;
		if (port.r_valid && port.r_ready) begin
			beat.dword <= port.r_data;
			resp_q <= port.r_resp;
		end
	end

	if (NARROW == 1) begin : g_narrow
		// addr bit 2 picks the instruction word
		assign up_r_data = {{(`DATA_WIDTH - `INSN_WIDTH){1'b0}}, beat.half[addr_q[2]]};
	end else begin : g_wide
		assign up_r_data = beat.dword;
	end

	// request must hold until the arbiter forwards it to the bus
	ar_hold_a: assert property (@(posedge clock) disable iff (reset)
		port.ar_valid && !port.ar_ready |=> port.ar_valid && $stable(port.ar_addr));

endmodule
